//--- logic/mips_id_settings.svh
`ifndef MIPS_ID_SETTINGS_SVH
`define MIPS_ID_SETTINGS_SVH

// data and instruction word
`define MIPS_NB 32

// register number field
`define MIPS_REGS 5

// raw immediate field
`define MIPS_INBITS 16

// opcode and funct fields
`define MIPS_CTRLNB 6

// general registers
`define MIPS_NREG 32

`endif

//--- logic/mips_isa_pkg.sv
`include "mips_id_settings.svh"

package mips_isa_pkg;

  // one data or instruction word
  typedef logic [`MIPS_NB-1:0] word_t;

  // register number, rs / rt / rd fields
  typedef logic [`MIPS_REGS-1:0] reg_addr_t;

  // immediate as it sits in the instruction
  typedef logic [`MIPS_INBITS-1:0] imm_t;

  // primary opcode, bits 31..26
  typedef enum logic [`MIPS_CTRLNB-1:0] {
    op_rtype = 6'h00,  // funct selects the op
    op_beq   = 6'h04,
    op_addi  = 6'h08,
    op_slti  = 6'h0a,
    op_andi  = 6'h0c,
    op_ori   = 6'h0d,
    op_xori  = 6'h0e,
    op_lui   = 6'h0f,
    op_lw    = 6'h23,
    op_sw    = 6'h2b
  } opcode_e;

  // R-type function, bits 5..0
  typedef enum logic [`MIPS_CTRLNB-1:0] {
    fn_sll = 6'h00,  // shamt in bits 10..6
    fn_srl = 6'h02,
    fn_add = 6'h20,
    fn_sub = 6'h22,
    fn_and = 6'h24,
    fn_or  = 6'h25,
    fn_xor = 6'h26,
    fn_slt = 6'h2a
  } funct_e;

endpackage

//--- logic/mips_ctrl_pkg.sv
package mips_ctrl_pkg;

  // how the 16-bit immediate is widened
  typedef enum logic [1:0] {
    ext_sign  = 2'b00,
    ext_zero  = 2'b01,  // logical immediates
    ext_upper = 2'b10   // lui
  } ext_mode_e;

  // class of work handed to the execute stage ALU control
  typedef enum logic [1:0] {
    aluop_add       = 2'b00,  // address calc and addi
    aluop_sub       = 2'b01,  // beq compare
    aluop_funct     = 2'b10,  // R-type, funct decides
    aluop_logic_imm = 2'b11   // opcode decides
  } alu_op_e;

endpackage

//--- logic/control_unit.sv
`timescale 1ns/100ps

module control_unit (
  input  mips_isa_pkg::opcode_e     i_opcode,
  input  mips_isa_pkg::funct_e      i_funct,
  output logic                      o_alu_src,
  output mips_ctrl_pkg::alu_op_e    o_alu_op,
  output mips_ctrl_pkg::ext_mode_e  o_ext_mode,
  output logic                      o_reg_dst,
  output logic                      o_reg_write,
  output logic                      o_mem_read,
  output logic                      o_mem_write,
  output logic                      o_branch,
  output logic                      o_illegal
);

  logic w_funct_ok;

  always_comb begin
    case (i_funct)
      mips_isa_pkg::fn_add,
      mips_isa_pkg::fn_sub,
      mips_isa_pkg::fn_and,
      mips_isa_pkg::fn_or,
      mips_isa_pkg::fn_xor,
      mips_isa_pkg::fn_slt,
      mips_isa_pkg::fn_sll,
      mips_isa_pkg::fn_srl: w_funct_ok = 1'b1;
      default:              w_funct_ok = 1'b0;
    endcase
  end

  always_comb begin
    o_alu_src   = 1'b0;  // register operand b
    o_alu_op    = mips_ctrl_pkg::aluop_add;
    o_ext_mode  = mips_ctrl_pkg::ext_sign;
    o_reg_dst   = 1'b0;  // rt
    o_reg_write = 1'b0;
    o_mem_read  = 1'b0;
    o_mem_write = 1'b0;
    o_branch    = 1'b0;
    o_illegal   = 1'b0;
    case (i_opcode)
      mips_isa_pkg::op_rtype: begin
        if (w_funct_ok) begin
          o_alu_op    = mips_ctrl_pkg::aluop_funct;
          o_reg_dst   = 1'b1;
          o_reg_write = 1'b1;
        end else begin
          o_illegal = 1'b1;
        end
      end
      mips_isa_pkg::op_beq: begin
        o_alu_op = mips_ctrl_pkg::aluop_sub;
        o_branch = 1'b1;
      end
      mips_isa_pkg::op_addi: begin
        o_alu_src   = 1'b1;
        o_reg_write = 1'b1;
      end
      mips_isa_pkg::op_slti: begin
        o_alu_src   = 1'b1;
        o_alu_op    = mips_ctrl_pkg::aluop_logic_imm;  // slt picked from opcode
        o_reg_write = 1'b1;
      end
      mips_isa_pkg::op_andi,
      mips_isa_pkg::op_ori,
      mips_isa_pkg::op_xori: begin
        o_alu_src   = 1'b1;
        o_alu_op    = mips_ctrl_pkg::aluop_logic_imm;
        o_ext_mode  = mips_ctrl_pkg::ext_zero;
        o_reg_write = 1'b1;
      end
      mips_isa_pkg::op_lui: begin
        o_alu_src   = 1'b1;  // rs field is zero, add passes it
        o_ext_mode  = mips_ctrl_pkg::ext_upper;
        o_reg_write = 1'b1;
      end
      mips_isa_pkg::op_lw: begin
        o_alu_src   = 1'b1;
        o_reg_write = 1'b1;
        o_mem_read  = 1'b1;
      end
      mips_isa_pkg::op_sw: begin
        o_alu_src   = 1'b1;
        o_mem_write = 1'b1;
      end
      default: o_illegal = 1'b1;  // enables stay low
    endcase
  end

  // a load writes back, a store must not
  always_comb begin
    a_no_write_and_store: assert (!(o_reg_write && o_mem_write))
      else $error("control_unit: reg write and mem write both set");
  end

endmodule

//--- logic/register_file.sv
`timescale 1ns/100ps
`include "mips_id_settings.svh"

module register_file (
  input  logic                    i_clk,
  input  logic                    i_rst_n,
  input  logic                    i_step,
  input  mips_isa_pkg::reg_addr_t i_rs_addr,
  input  mips_isa_pkg::reg_addr_t i_rt_addr,
  input  mips_isa_pkg::reg_addr_t i_dbg_addr,  // from debug unit
  input  logic                    i_wb_en,
  input  mips_isa_pkg::reg_addr_t i_wb_addr,
  input  mips_isa_pkg::word_t     i_wb_data,
  output mips_isa_pkg::word_t     o_rs_data,
  output mips_isa_pkg::word_t     o_rt_data,
  output mips_isa_pkg::word_t     o_dbg_data
);

  mips_isa_pkg::word_t r_regs [`MIPS_NREG];
  logic                w_wr;

  // $zero never takes a write
  assign w_wr = i_step && i_wb_en && (i_wb_addr != '0);

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      for (int i = 0; i < `MIPS_NREG; i++) begin
        r_regs[i] <= '0;
      end
    end else if (w_wr) begin
      r_regs[i_wb_addr] <= i_wb_data;
    end
  end

  function automatic mips_isa_pkg::word_t read_reg(input mips_isa_pkg::reg_addr_t addr);
    if (addr == '0) begin
      return '0;  // hardwired
    end
    return r_regs[addr];
  endfunction

  assign o_rs_data  = read_reg(i_rs_addr);
  assign o_rt_data  = read_reg(i_rt_addr);
  assign o_dbg_data = read_reg(i_dbg_addr);

  // storage for $zero stays clear once out of reset
  a_zero_reg: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    r_regs[0] == '0)
    else $error("register_file: register 0 holds a nonzero value");

endmodule

//--- logic/imm_extender.sv
`timescale 1ns/100ps
`include "mips_id_settings.svh"

module imm_extender (
  input  mips_isa_pkg::imm_t       i_imm,
  input  mips_ctrl_pkg::ext_mode_e i_ext_mode,
  output mips_isa_pkg::word_t      o_ext_imm
);

  always_comb begin
    case (i_ext_mode)
      mips_ctrl_pkg::ext_zero:
        o_ext_imm = {{(`MIPS_NB-`MIPS_INBITS){1'b0}}, i_imm};
      mips_ctrl_pkg::ext_upper:
        o_ext_imm = {i_imm, {(`MIPS_NB-`MIPS_INBITS){1'b0}}};  // lui
      default:
        o_ext_imm = {{(`MIPS_NB-`MIPS_INBITS){i_imm[`MIPS_INBITS-1]}}, i_imm};
    endcase
  end

  // control_unit only issues the three listed modes
  always_comb begin
    if (!$isunknown(i_ext_mode)) begin
      a_ext_mode_known: assert (i_ext_mode inside {mips_ctrl_pkg::ext_sign,
                                                   mips_ctrl_pkg::ext_zero,
                                                   mips_ctrl_pkg::ext_upper})
        else $error("imm_extender: unlisted extension mode %b", i_ext_mode);
    end
  end

endmodule

//--- logic/mips_decode_stage.sv
`timescale 1ns/100ps
`include "mips_id_settings.svh"

module mips_decode_stage (
  input  logic                     i_clk,
  input  logic                     i_rst_n,
  input  logic                     i_step,
  input  mips_isa_pkg::word_t      i_instruction,
  input  mips_isa_pkg::reg_addr_t  i_dbg_reg,
  input  logic                     i_wb_en,
  input  mips_isa_pkg::reg_addr_t  i_wb_reg,
  input  mips_isa_pkg::word_t      i_wb_data,
  output mips_isa_pkg::word_t      o_data_a,
  output mips_isa_pkg::word_t      o_data_b,
  output mips_isa_pkg::word_t      o_ext_imm,
  output mips_isa_pkg::word_t      o_dbg_data,
  output mips_isa_pkg::reg_addr_t  o_dest_reg,
  output mips_isa_pkg::opcode_e    o_opcode,
  output mips_isa_pkg::funct_e     o_funct,
  output logic                     o_alu_src,
  output mips_ctrl_pkg::alu_op_e   o_alu_op,
  output logic                     o_reg_write,
  output logic                     o_mem_read,
  output logic                     o_mem_write,
  output logic                     o_branch,
  output logic                     o_illegal
);

  mips_isa_pkg::reg_addr_t  w_rs;
  mips_isa_pkg::reg_addr_t  w_rt;
  mips_isa_pkg::reg_addr_t  w_rd;
  mips_isa_pkg::imm_t       w_imm;
  mips_ctrl_pkg::ext_mode_e w_ext_mode;
  logic                     w_reg_dst;

  assign o_opcode = mips_isa_pkg::opcode_e'(i_instruction[`MIPS_NB-1 -: `MIPS_CTRLNB]);
  assign o_funct  = mips_isa_pkg::funct_e'(i_instruction[`MIPS_CTRLNB-1:0]);
  assign w_rs     = i_instruction[`MIPS_INBITS+2*`MIPS_REGS-1 -: `MIPS_REGS];  // 25..21
  assign w_rt     = i_instruction[`MIPS_INBITS+`MIPS_REGS-1 -: `MIPS_REGS];    // 20..16
  assign w_rd     = i_instruction[`MIPS_INBITS-1 -: `MIPS_REGS];               // 15..11
  assign w_imm    = i_instruction[`MIPS_INBITS-1:0];

  assign o_dest_reg = w_reg_dst ? w_rd : w_rt;  // rd for R-type

  control_unit u_control_unit (
    .i_opcode   (o_opcode),
    .i_funct    (o_funct),
    .o_alu_src  (o_alu_src),
    .o_alu_op   (o_alu_op),
    .o_ext_mode (w_ext_mode),
    .o_reg_dst  (w_reg_dst),
    .o_reg_write(o_reg_write),
    .o_mem_read (o_mem_read),
    .o_mem_write(o_mem_write),
    .o_branch   (o_branch),
    .o_illegal  (o_illegal)
  );

  register_file u_register_file (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_step    (i_step),
    .i_rs_addr (w_rs),
    .i_rt_addr (w_rt),
    .i_dbg_addr(i_dbg_reg),
    .i_wb_en   (i_wb_en),
    .i_wb_addr (i_wb_reg),
    .i_wb_data (i_wb_data),
    .o_rs_data (o_data_a),
    .o_rt_data (o_data_b),
    .o_dbg_data(o_dbg_data)
  );

  imm_extender u_imm_extender (
    .i_imm     (w_imm),
    .i_ext_mode(w_ext_mode),
    .o_ext_imm (o_ext_imm)
  );

endmodule

//--- bench/tb_mips_decode_stage.sv
`timescale 1ns/100ps
`include "mips_id_settings.svh"

module tb_mips_decode_stage;

  localparam int SWEEP_WRITES  = 200;
  localparam int RESET_TIMEOUT = 50;   // cycles
  localparam int TRACE_LIMIT   = 500;  // trace items

  logic                     i_clk;
  logic                     i_rst_n;
  logic                     i_step;
  mips_isa_pkg::word_t      i_instruction;
  mips_isa_pkg::reg_addr_t  i_dbg_reg;
  logic                     i_wb_en;
  mips_isa_pkg::reg_addr_t  i_wb_reg;
  mips_isa_pkg::word_t      i_wb_data;
  mips_isa_pkg::word_t      o_data_a;
  mips_isa_pkg::word_t      o_data_b;
  mips_isa_pkg::word_t      o_ext_imm;
  mips_isa_pkg::word_t      o_dbg_data;
  mips_isa_pkg::reg_addr_t  o_dest_reg;
  mips_isa_pkg::opcode_e    o_opcode;
  mips_isa_pkg::funct_e     o_funct;
  logic                     o_alu_src;
  mips_ctrl_pkg::alu_op_e   o_alu_op;
  logic                     o_reg_write;
  logic                     o_mem_read;
  logic                     o_mem_write;
  logic                     o_branch;
  logic                     o_illegal;

  mips_isa_pkg::word_t model_regs [`MIPS_NREG];  // expected register contents
  logic [31:0]         lcg_state;
  logic                run_ok;
  int                  tests;
  int                  checks;
  int                  errors;

  mips_decode_stage UUT (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_step       (i_step),
    .i_instruction(i_instruction),
    .i_dbg_reg    (i_dbg_reg),
    .i_wb_en      (i_wb_en),
    .i_wb_reg     (i_wb_reg),
    .i_wb_data    (i_wb_data),
    .o_data_a     (o_data_a),
    .o_data_b     (o_data_b),
    .o_ext_imm    (o_ext_imm),
    .o_dbg_data   (o_dbg_data),
    .o_dest_reg   (o_dest_reg),
    .o_opcode     (o_opcode),
    .o_funct      (o_funct),
    .o_alu_src    (o_alu_src),
    .o_alu_op     (o_alu_op),
    .o_reg_write  (o_reg_write),
    .o_mem_read   (o_mem_read),
    .o_mem_write  (o_mem_write),
    .o_branch     (o_branch),
    .o_illegal    (o_illegal)
  );

  initial begin
    i_clk = 1'b0;
  end

  always #20 i_clk = ~i_clk;  // 40 ns period

  initial begin
    i_rst_n <= 1'b0;
    repeat (10) @(posedge i_clk);
    i_rst_n <= 1'b1;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check_word(input mips_isa_pkg::word_t got, input mips_isa_pkg::word_t exp,
                            input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_reg(input mips_isa_pkg::reg_addr_t got,
                           input mips_isa_pkg::reg_addr_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t ns: %s is r%0d, expected r%0d", $time, what, got, exp);
    end
  endtask

  task automatic check_opcode(input mips_isa_pkg::opcode_e got,
                              input mips_isa_pkg::opcode_e exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_funct(input mips_isa_pkg::funct_e got,
                             input mips_isa_pkg::funct_e exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_alu_op(input mips_ctrl_pkg::alu_op_e got,
                              input mips_ctrl_pkg::alu_op_e exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t ns: %s is %s, expected %s", $time, what, got.name(), exp.name());
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    tests++;
    if (errors == err_before) begin
      $display("test %0d %s: ok", tests, name);
    end else begin
      $display("test %0d %s: %0d errors", tests, name, errors - err_before);
    end
  endtask

  // one write-back pulse, model follows the step, enable and r0 rules
  task automatic write_back(input logic step, input logic en,
                            input mips_isa_pkg::reg_addr_t wr_reg,
                            input mips_isa_pkg::word_t data);
    @(posedge i_clk);
    i_step    <= step;
    i_wb_en   <= en;
    i_wb_reg  <= wr_reg;
    i_wb_data <= data;
    @(posedge i_clk);
    i_step  <= 1'b0;
    i_wb_en <= 1'b0;
    if (step && en && wr_reg != '0) begin
      model_regs[wr_reg] = data;
    end
  endtask

  task automatic wait_for_reset(output logic ok);
    int cycles;
    cycles = 0;
    while (i_rst_n !== 1'b1 && cycles < RESET_TIMEOUT) begin
      @(posedge i_clk);
      cycles++;
    end
    ok = (i_rst_n === 1'b1);
    if (!ok) begin
      $display("reset was still asserted after %0d cycles", RESET_TIMEOUT);
    end
  endtask

  task automatic check_reset_state();
    int err_before;
    err_before = errors;
    for (int r = 0; r < `MIPS_NREG; r++) begin
      @(posedge i_clk);
      i_dbg_reg <= mips_isa_pkg::reg_addr_t'(r);
      @(negedge i_clk);
      check_word(o_dbg_data, '0, $sformatf("debug r%0d after reset", r));
    end
    report_test("registers clear after reset", err_before);
  endtask

  task automatic run_trace(output logic ok);
    int          fd;
    int          code;
    int          items;
    int          err_before;
    logic        done;
    logic [7:0]  kind;
    logic [8*160-1:0] skip_buf;
    logic [31:0] t_step;
    logic [31:0] t_reg;
    logic [31:0] t_data;
    logic [31:0] t_instr;
    logic [31:0] t_a;
    logic [31:0] t_b;
    logic [31:0] t_imm;
    logic [31:0] t_dest;
    logic [31:0] t_src;
    logic [31:0] t_op;
    logic [31:0] t_rw;
    logic [31:0] t_mr;
    logic [31:0] t_mw;
    logic [31:0] t_br;
    logic [31:0] t_ill;
    ok = 1'b1;
    fd = $fopen("bench/decode_trace.txt", "r");
    if (fd == 0) begin
      $display("could not open bench/decode_trace.txt");
      ok = 1'b0;
      return;
    end
    items = 0;
    done  = 1'b0;
    while (!done && items < TRACE_LIMIT) begin
      code = $fscanf(fd, " %c", kind);
      if (code != 1) begin
        done = 1'b1;  // end of file
      end else if (kind == "#") begin
        void'($fgets(skip_buf, fd));
      end else begin
        items++;
        err_before = errors;
        case (kind)
          "W": begin
            code = $fscanf(fd, "%h %h %h", t_step, t_reg, t_data);
            if (code != 3) begin
              errors++;
              $display("trace item %0d has a broken write line", items);
            end else begin
              write_back(t_step[0], 1'b1, t_reg[`MIPS_REGS-1:0], t_data);
            end
          end
          "D": begin
            code = $fscanf(fd, "%h %h", t_reg, t_data);
            if (code != 2) begin
              errors++;
              $display("trace item %0d has a broken debug line", items);
            end else begin
              @(posedge i_clk);
              i_dbg_reg <= t_reg[`MIPS_REGS-1:0];
              @(negedge i_clk);
              check_word(o_dbg_data, t_data, "dbg_data");
              report_test($sformatf("debug read r%0d", t_reg), err_before);
            end
          end
          "I": begin
            code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h", t_instr, t_a, t_b,
                           t_imm, t_dest, t_src, t_op, t_rw, t_mr, t_mw, t_br, t_ill);
            if (code != 12) begin
              errors++;
              $display("trace item %0d has a broken decode line", items);
            end else begin
              @(posedge i_clk);
              i_instruction <= t_instr;
              @(negedge i_clk);
              check_word(o_data_a, t_a, "data_a");
              check_word(o_data_b, t_b, "data_b");
              check_word(o_ext_imm, t_imm, "ext_imm");
              check_reg(o_dest_reg, t_dest[`MIPS_REGS-1:0], "dest_reg");
              check_opcode(o_opcode, mips_isa_pkg::opcode_e'(t_instr[31:26]), "opcode");
              check_funct(o_funct, mips_isa_pkg::funct_e'(t_instr[5:0]), "funct");
              check_flag(o_alu_src, t_src[0], "alu_src");
              check_alu_op(o_alu_op, mips_ctrl_pkg::alu_op_e'(t_op[1:0]), "alu_op");
              check_flag(o_reg_write, t_rw[0], "reg_write");
              check_flag(o_mem_read, t_mr[0], "mem_read");
              check_flag(o_mem_write, t_mw[0], "mem_write");
              check_flag(o_branch, t_br[0], "branch");
              check_flag(o_illegal, t_ill[0], "illegal");
              report_test($sformatf("decode %h", t_instr), err_before);
            end
          end
          default: begin
            errors++;
            $display("trace item %0d starts with an unknown kind letter", items);
          end
        endcase
      end
    end
    if (!done) begin
      $display("trace reading stopped after %0d items without reaching the end", items);
      ok = 1'b0;
    end
    $fclose(fd);
  endtask

  // R-type add whose rs and rt fields pick the registers to read
  task automatic read_through_decode(input mips_isa_pkg::reg_addr_t rs,
                                     input mips_isa_pkg::reg_addr_t rt,
                                     input mips_isa_pkg::reg_addr_t dbg);
    @(posedge i_clk);
    i_instruction <= {mips_isa_pkg::op_rtype, rs, rt, 5'd1, 5'd0, mips_isa_pkg::fn_add};
    i_dbg_reg     <= dbg;
    @(negedge i_clk);
    check_word(o_data_a, model_regs[rs], $sformatf("data_a for r%0d", rs));
    check_word(o_data_b, model_regs[rt], $sformatf("data_b for r%0d", rt));
    check_word(o_dbg_data, model_regs[dbg], $sformatf("dbg_data for r%0d", dbg));
  endtask

  task automatic lcg_sweep();
    mips_isa_pkg::reg_addr_t wr_reg;
    mips_isa_pkg::reg_addr_t rs;
    mips_isa_pkg::reg_addr_t rt;
    mips_isa_pkg::word_t     data;
    logic                    step;
    logic                    en;
    int                      err_before;
    err_before = errors;
    for (int n = 0; n < SWEEP_WRITES; n++) begin
      lcg_state = lcg_next(lcg_state);
      wr_reg    = lcg_state[30:26];
      step      = (lcg_state[25:24] != 2'b00);  // about one write in four is held off
      en        = (lcg_state[23:22] != 2'b00);  // and one in four has no enable
      lcg_state = lcg_next(lcg_state);
      data      = lcg_state;
      write_back(step, en, wr_reg, data);
      lcg_state = lcg_next(lcg_state);
      rs        = lcg_state[30:26];
      rt        = lcg_state[24:20];
      read_through_decode(rs, rt, wr_reg);
    end
    report_test($sformatf("random write sweep, %0d writes", SWEEP_WRITES), err_before);
  endtask

  task automatic finish_run(input logic ok);
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (ok && errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  endtask

  initial begin
    i_step        <= 1'b0;
    i_instruction <= '0;
    i_dbg_reg     <= '0;
    i_wb_en       <= 1'b0;
    i_wb_reg      <= '0;
    i_wb_data     <= '0;
    tests     = 0;
    checks    = 0;
    errors    = 0;
    lcg_state = 32'hdd7e_80a0;
    for (int r = 0; r < `MIPS_NREG; r++) begin
      model_regs[r] = '0;
    end
    wait_for_reset(run_ok);
    if (run_ok) begin
      check_reset_state();
      run_trace(run_ok);
    end
    if (run_ok) begin
      lcg_sweep();
    end
    finish_run(run_ok);
  end

endmodule

//--- mips_id.f
+incdir+logic
logic/mips_isa_pkg.sv
logic/mips_ctrl_pkg.sv
logic/control_unit.sv
logic/register_file.sv
logic/imm_extender.sv
logic/mips_decode_stage.sv
bench/tb_mips_decode_stage.sv

//--- run_sim.sh
#!/bin/sh
# build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_mips_decode_stage
OBJ=obj_dir
LOG=sim.log

verilator --binary --timing --assert \
  -f mips_id.f \
  --top-module "$TOP" \
  --Mdir "$OBJ" \
  -o "$TOP"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$OBJ/$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -qF "*** TEST PASSED ***" "$LOG"; then
  exit 0
else
  echo "pass message not found in $LOG"
  exit 1
fi

//--- bench/decode_trace.txt
# W step reg data | D reg value | all fields hex
# I instr data_a data_b ext_imm dest alu_src alu_op reg_write mem_read mem_write branch illegal
W 1 01 12345678
W 1 02 fffffff0
D 01 12345678
D 02 fffffff0
W 0 03 deadbeef
D 03 00000000
I 00632020 00000000 00000000 00002020 04 0 2 1 0 0 0 0
W 1 00 cafef00d
D 00 00000000
I 00000000 00000000 00000000 00000000 00 0 2 1 0 0 0 0
W 1 03 0000abcd
D 03 0000abcd
W 1 1f 80000001
D 1f 80000001
I 00222020 12345678 fffffff0 00002020 04 0 2 1 0 0 0 0
I 00612822 0000abcd 12345678 00002822 05 0 2 1 0 0 0 0
I 005f302a fffffff0 80000001 0000302a 06 0 2 1 0 0 0 0
I 00013900 00000000 12345678 00003900 07 0 2 1 0 0 0 0
I 00034042 00000000 0000abcd 00004042 08 0 2 1 0 0 0 0
I 00234824 12345678 0000abcd 00004824 09 0 2 1 0 0 0 0
I 00435025 fffffff0 0000abcd 00005025 0a 0 2 1 0 0 0 0
I 03e15826 80000001 12345678 00005826 0b 0 2 1 0 0 0 0
I 0022603f 12345678 fffffff0 0000603f 02 0 0 0 0 0 0 1
I 202cfffc 12345678 00000000 fffffffc 0c 1 0 1 0 0 0 0
I 204d1234 fffffff0 00000000 00001234 0d 1 0 1 0 0 0 0
I 346e8001 0000abcd 00000000 00008001 0e 1 3 1 0 0 0 0
I 340f7fff 00000000 00000000 00007fff 0f 1 3 1 0 0 0 0
I 3c108765 00000000 00000000 87650000 10 1 0 1 0 0 0 0
I 3c111234 00000000 00000000 12340000 11 1 0 1 0 0 0 0
I 3032ff00 12345678 00000000 0000ff00 12 1 3 1 0 0 0 0
I 3bf3a5a5 80000001 00000000 0000a5a5 13 1 3 1 0 0 0 0
I 2854ffff fffffff0 00000000 ffffffff 14 1 3 1 0 0 0 0
I 8c240008 12345678 00000000 00000008 04 1 0 1 1 0 0 0
I ac43fff0 fffffff0 0000abcd fffffff0 03 1 0 0 0 1 0 0
I 1022fffe 12345678 fffffff0 fffffffe 02 0 1 0 0 0 1 0
I fc221234 12345678 fffffff0 00001234 02 0 0 0 0 0 0 1
I 08000100 00000000 00000000 00000100 00 0 0 0 0 0 0 1
